//--- src/mem_defines.svh
// ==============================
// sizing macros for the memory front end
// byte enables are WORD_W/8 bits wide
// ADDR_W is a byte address, RAM ignores low bits
// RAM_LATENCY must be at least 1
// ==============================
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// data word width in bits
`define WORD_W 32

// byte address width
`define ADDR_W 32

// default RAM depth in words and completion latency in cycles
`define RAM_DEPTH_WORDS 256
`define RAM_LATENCY 2

`endif

//--- src/mem_pkg.sv
// ==============================
// shared request/response types
// busy is high except in the one completion cycle
// ren and wen are never both high
// ==============================
`include "mem_defines.svh"

package mem_pkg;

  // data port request, also used on the RAM side
  typedef struct packed {
    logic                    ren;
    logic                    wen;
    logic [`ADDR_W-1:0]      addr;
    logic [`WORD_W-1:0]      wdata;
    logic [`WORD_W/8-1:0]    byte_en;
  } mem_req_t;

  // instruction fetch request, read only
  typedef struct packed {
    logic               ren;
    logic [`ADDR_W-1:0] addr;
  } fetch_req_t;

  // response on every port
  typedef struct packed {
    logic               busy;
    logic [`WORD_W-1:0] rdata;
  } mem_rsp_t;

  // arbiter states, one transfer in flight at most
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_DATA,
    ARB_FETCH
  } arb_state_t;

endpackage

//--- src/memory_controller.sv
// ==============================
// data/fetch arbiter in front of one RAM port
// data has priority, fetch follows a data transfer
// sub-word writes need aligned byte enables
// requests must be held stable while busy is high
// ==============================
`timescale 1ns/1ps

module memory_controller import mem_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  mem_req_t   i_dreq,
  input  fetch_req_t i_ireq,
  output mem_rsp_t   o_drsp,
  output mem_rsp_t   o_irsp,
  output mem_req_t   o_ram_req,
  input  mem_rsp_t   i_ram_rsp
);

  arb_state_t arb_q;
  arb_state_t arb_d;

  // pending requests on each port
  logic d_pend;
  logic i_pend;

  // RAM finished the current transfer this cycle
  logic xfer_done;

  // store data moved onto the enabled byte lanes
  logic [$bits(i_dreq.wdata)-1:0] wdata_aligned;

  assign d_pend    = i_dreq.ren | i_dreq.wen;
  assign i_pend    = i_ireq.ren;
  assign xfer_done = (arb_q != ARB_IDLE) && !i_ram_rsp.busy;

  // state register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      arb_q <= ARB_IDLE;
    end else begin
      arb_q <= arb_d;
    end
  end

  // next state
  always_comb begin
    arb_d = arb_q;
    case (arb_q)
      ARB_IDLE: begin
        // data wins a tie
        if (d_pend) begin
          arb_d = ARB_DATA;
        end else if (i_pend) begin
          arb_d = ARB_FETCH;
        end
      end
      ARB_DATA: begin
        // hand over to a waiting fetch right away
        if (xfer_done) begin
          arb_d = i_pend ? ARB_FETCH : ARB_IDLE;
        end
      end
      ARB_FETCH: begin
        // always back to idle so data gets a turn
        if (xfer_done) begin
          arb_d = ARB_IDLE;
        end
      end
      default: begin
        arb_d = ARB_IDLE;
      end
    endcase
  end

  // lane alignment, data sits in the low bits of wdata
  always_comb begin
    case (i_dreq.byte_en)
      4'b1111, 4'b0001, 4'b0011: wdata_aligned = i_dreq.wdata;
      4'b0010:                   wdata_aligned = i_dreq.wdata << 8;
      4'b0100, 4'b1100:          wdata_aligned = i_dreq.wdata << 16;
      4'b1000:                   wdata_aligned = i_dreq.wdata << 24;
      // unsupported pattern, passed through and caught below
      default:                   wdata_aligned = i_dreq.wdata;
    endcase
  end

  // route the granted port onto the RAM
  always_comb begin
    o_ram_req = '0;
    case (arb_q)
      ARB_DATA: begin
        o_ram_req.ren     = i_dreq.ren;
        o_ram_req.wen     = i_dreq.wen;
        o_ram_req.addr    = i_dreq.addr;
        o_ram_req.wdata   = wdata_aligned;
        o_ram_req.byte_en = i_dreq.byte_en;
      end
      ARB_FETCH: begin
        // fetch is a full-word read
        o_ram_req.ren     = i_ireq.ren;
        o_ram_req.wen     = 1'b0;
        o_ram_req.addr    = i_ireq.addr;
        o_ram_req.byte_en = '1;
      end
      default: begin
        // idle, ren/wen stay low
        o_ram_req = '0;
      end
    endcase
  end

  // busy goes only to the granted port
  // read data fans out to both unshifted
  always_comb begin
    o_drsp.busy  = (arb_q == ARB_DATA) ? i_ram_rsp.busy : 1'b1;
    o_drsp.rdata = i_ram_rsp.rdata;
    o_irsp.busy  = (arb_q == ARB_FETCH) ? i_ram_rsp.busy : 1'b1;
    o_irsp.rdata = i_ram_rsp.rdata;
  end

  // data port never reads and writes at once
  a_dreq_excl: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(i_dreq.ren && i_dreq.wen)
  ) else $error("data port ren and wen both high");

  // only aligned sub-word patterns are supported
  a_byte_en_ok: assert property (
    @(posedge CLK) disable iff (!nRST)
    i_dreq.wen |-> (i_dreq.byte_en inside
      {4'b1111, 4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100})
  ) else $error("unsupported byte_en %b", i_dreq.byte_en);

  // a transfer state is held until the RAM completes
  a_hold_xfer: assert property (
    @(posedge CLK) disable iff (!nRST)
    ((arb_q != ARB_IDLE) && i_ram_rsp.busy) |=> $stable(arb_q)
  ) else $error("left transfer state while RAM busy");

endmodule

//--- src/ram_model.sv
// ==============================
// behavioral word RAM with fixed latency
// contents are not reset, write before read
// address taken modulo DEPTH words
// LATENCY counts from the first request cycle
// ==============================
`timescale 1ns/1ps
`include "mem_defines.svh"

module ram_model import mem_pkg::*; #(
  parameter int DEPTH   = `RAM_DEPTH_WORDS,
  parameter int LATENCY = `RAM_LATENCY
) (
  input  logic     CLK,
  input  logic     nRST,
  input  mem_req_t i_req,
  output mem_rsp_t o_rsp
);

  localparam int LANES = `WORD_W / 8;
  localparam int OFS_W = $clog2(LANES);
  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

  logic [`WORD_W-1:0] mem [DEPTH];

  // word address and array index
  logic [`ADDR_W-OFS_W-1:0] word_addr;
  logic [IDX_W-1:0]         idx;

  // cycles already spent on the current request
  logic [CNT_W-1:0] cnt;
  logic             req_act;
  logic             done;

  assign word_addr = i_req.addr[`ADDR_W-1:OFS_W];
  assign idx       = IDX_W'(word_addr % DEPTH);
  assign req_act   = i_req.ren | i_req.wen;

  // completion in the LATENCY-th cycle of the request
  assign done = req_act && (cnt == CNT_W'(LATENCY - 1));

  // latency counter, rearms after completion
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt <= '0;
    end else if (done) begin
      cnt <= '0;
    end else if (req_act) begin
      cnt <= cnt + 1'b1;
    end else begin
      cnt <= '0;
    end
  end

  // byte-lane write at the completion edge
  always_ff @(posedge CLK) begin
    if (done && i_req.wen) begin
      for (int b = 0; b < LANES; b++) begin
        if (i_req.byte_en[b]) begin
          mem[idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
        end
      end
    end
  end

  // busy low only in the completion cycle
  // rdata is zero outside it
  always_comb begin
    o_rsp.busy  = ~done;
    o_rsp.rdata = done ? mem[idx] : '0;
  end

  // zero latency would complete before the request is seen
  initial begin
    a_latency_min: assert (LATENCY >= 1)
      else $fatal(1, "ram_model LATENCY must be at least 1, got %0d", LATENCY);
  end

  // requester holds its request until completion
  a_req_stable: assert property (
    @(posedge CLK) disable iff (!nRST)
    (req_act && o_rsp.busy) |=> $stable(i_req)
  ) else $error("RAM request changed while busy");

endmodule

//--- src/mem_subsystem_top.sv
// ==============================
// controller plus RAM model
// one transfer in flight, data before fetch
// idle latency is 1 + RAM_LATENCY cycles
// ==============================
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_subsystem_top import mem_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  mem_req_t   i_dreq,
  input  fetch_req_t i_ireq,
  output mem_rsp_t   o_drsp,
  output mem_rsp_t   o_irsp
);

  // controller to RAM
  mem_req_t ram_req;

  // RAM back to controller
  mem_rsp_t ram_rsp;

  // arbiter, lane alignment and busy fan-out
  memory_controller ctrl_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .i_dreq    (i_dreq),
    .i_ireq    (i_ireq),
    .o_drsp    (o_drsp),
    .o_irsp    (o_irsp),
    .o_ram_req (ram_req),
    .i_ram_rsp (ram_rsp)
  );

  // shared word RAM
  ram_model #(
    .DEPTH   (`RAM_DEPTH_WORDS),
    .LATENCY (`RAM_LATENCY)
  ) ram_i (
    .CLK   (CLK),
    .nRST  (nRST),
    .i_req (ram_req),
    .o_rsp (ram_rsp)
  );

endmodule

//--- dv/tb_mem_subsystem.sv
// ==============================
// testbench for mem_subsystem_top
// shadow memory tracks every completed write
// only addresses already written are read
// every handshake wait is capped at 200 cycles
// ==============================
`timescale 1ns/1ps
`include "mem_defines.svh"

module tb_mem_subsystem import mem_pkg::*; ();

  localparam int TIMEOUT = 200;
  localparam int N_WORDS = 16;
  localparam int DEPTH   = `RAM_DEPTH_WORDS;

  // one completed read, queued for the checker
  typedef struct packed {
    logic               is_fetch;
    logic [`ADDR_W-1:0] addr;
    logic [`WORD_W-1:0] got;
    logic [`WORD_W-1:0] exp;
  } rd_rec_t;

  logic       CLK = 1'b0;
  logic       nRST;
  mem_req_t   dreq;
  fetch_req_t ireq;
  mem_rsp_t   drsp;
  mem_rsp_t   irsp;

  // shadow of the RAM, keyed by word index
  logic [`WORD_W-1:0] shadow [int];
  rd_rec_t            rd_q [$];

  // supported byte enable patterns
  logic [3:0] be_tab [7] = '{4'b1111, 4'b0001, 4'b0010, 4'b0100,
                             4'b1000, 4'b0011, 4'b1100};

  // port activity as seen by the monitor
  bit d_req_on;
  bit i_req_on;

  int cyc;
  int d_done_cyc;
  int i_done_cyc;
  int n_reads;
  int n_mismatch;
  int n_order;
  int n_busy;
  int n_timeout;

  mem_subsystem_top dut_i (
    .CLK    (CLK),
    .nRST   (nRST),
    .i_dreq (dreq),
    .i_ireq (ireq),
    .o_drsp (drsp),
    .o_irsp (irsp)
  );

  initial begin
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cyc <= cyc + 1;
  end

  // spread the test words over the RAM
  function automatic logic [`ADDR_W-1:0] addr_of(input int i);
    return `ADDR_W'(32'h80 + (i << 3));
  endfunction

  // reference model of one access
  // store data sits in the low bits and moves up to the lowest enabled lane
  function automatic logic [`WORD_W-1:0] shadow_ref(input bit is_wr,
      input logic [`ADDR_W-1:0] addr, input logic [`WORD_W-1:0] wdata,
      input logic [3:0] be);
    int                 idx;
    int                 sh;
    int                 b;
    logic [`WORD_W-1:0] moved;
    logic [`WORD_W-1:0] word;
    idx  = int'((addr >> 2) % DEPTH);
    word = shadow.exists(idx) ? shadow[idx] : '0;
    if (is_wr) begin
      sh = 0;
      while (sh < 3 && !be[sh]) begin
        sh++;
      end
      moved = wdata << (8 * sh);
      for (b = 0; b < 4; b++) begin
        if (be[b]) begin
          word[8*b +: 8] = moved[8*b +: 8];
        end
      end
      shadow[idx] = word;
    end
    return word;
  endfunction

  // one data port transfer, held until busy drops
  task automatic data_access(input bit wr, input logic [`ADDR_W-1:0] addr,
      input logic [`WORD_W-1:0] wdata, input logic [3:0] be);
    mem_req_t req;
    rd_rec_t  rec;
    int       waited;
    req         = '0;
    req.ren     = !wr;
    req.wen     = wr;
    req.addr    = addr;
    req.wdata   = wdata;
    req.byte_en = be;
    @(posedge CLK);
    dreq     <= req;
    d_req_on  = 1'b1;
    waited    = 0;
    @(negedge CLK);
    while (drsp.busy && waited < TIMEOUT) begin
      waited++;
      @(negedge CLK);
    end
    if (drsp.busy) begin
      n_timeout++;
      $display("timeout: data access at 0x%08h not served within %0d cycles", addr, TIMEOUT);
    end else begin
      // completion cycle, rdata valid here
      d_done_cyc   = cyc;
      rec.is_fetch = 1'b0;
      rec.addr     = addr;
      rec.got      = drsp.rdata;
      rec.exp      = shadow_ref(wr, addr, wdata, be);
      if (!wr) begin
        rd_q.push_back(rec);
      end
    end
    @(posedge CLK);
    dreq     <= '0;
    d_req_on  = 1'b0;
  endtask

  // one instruction fetch
  task automatic fetch_word(input logic [`ADDR_W-1:0] addr);
    fetch_req_t req;
    rd_rec_t    rec;
    int         waited;
    req.ren  = 1'b1;
    req.addr = addr;
    @(posedge CLK);
    ireq     <= req;
    i_req_on  = 1'b1;
    waited    = 0;
    @(negedge CLK);
    while (irsp.busy && waited < TIMEOUT) begin
      waited++;
      @(negedge CLK);
    end
    if (irsp.busy) begin
      n_timeout++;
      $display("timeout: fetch at 0x%08h not served within %0d cycles", addr, TIMEOUT);
    end else begin
      i_done_cyc   = cyc;
      rec.is_fetch = 1'b1;
      rec.addr     = addr;
      rec.got      = irsp.rdata;
      rec.exp      = shadow_ref(1'b0, addr, '0, 4'hF);
      rd_q.push_back(rec);
    end
    @(posedge CLK);
    ireq     <= '0;
    i_req_on  = 1'b0;
  endtask

  task automatic random_data_traffic(input int n);
    int k;
    repeat (n) begin
      k = $urandom_range(N_WORDS - 1, 0);
      if ($urandom_range(1, 0) == 1) begin
        data_access(1'b1, addr_of(k), $urandom, be_tab[$urandom_range(6, 0)]);
      end else begin
        data_access(1'b0, addr_of(k), '0, 4'hF);
      end
    end
  endtask

  task automatic random_fetch_traffic(input int n);
    repeat (n) begin
      fetch_word(addr_of($urandom_range(N_WORDS - 1, 0)));
    end
  endtask

  // compare every completed read against the shadow
  always @(posedge CLK) begin
    rd_rec_t r;
    while (rd_q.size() > 0) begin
      r = rd_q.pop_front();
      n_reads++;
      assert (r.got === r.exp) else begin
        n_mismatch++;
        $display("** Error: %s = 0x%08h, expected 0x%08h at addr 0x%08h",
                 r.is_fetch ? "o_irsp.rdata" : "o_drsp.rdata", r.got, r.exp, r.addr);
      end
    end
  end

  // busy stays high in reset and whenever a port has no request
  always @(negedge CLK) begin
    assert (drsp.busy === 1'b1 || d_req_on) else begin
      n_busy++;
      $display("** Error: o_drsp.busy = 0x%0h with no data request, expected 0x1", drsp.busy);
    end
    assert (irsp.busy === 1'b1 || i_req_on) else begin
      n_busy++;
      $display("** Error: o_irsp.busy = 0x%0h with no fetch request, expected 0x1", irsp.busy);
    end
  end

  initial begin
    int i;
    void'($urandom(32'h5770));
    nRST = 1'b0;
    dreq = '0;
    ireq = '0;
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
    // idle stretch, monitor watches busy
    repeat (6) @(posedge CLK);

    // full words
    for (i = 0; i < N_WORDS; i++) begin
      data_access(1'b1, addr_of(i), $urandom, 4'hF);
    end
    for (i = 0; i < N_WORDS; i++) begin
      data_access(1'b0, addr_of(i), '0, 4'hF);
    end

    // sub-word lanes on known words
    for (i = 1; i < 7; i++) begin
      data_access(1'b1, addr_of(i), $urandom, be_tab[i]);
    end
    for (i = 1; i < 7; i++) begin
      data_access(1'b0, addr_of(i), '0, 4'hF);
    end

    // fetch, then confirm memory untouched
    for (i = 0; i < N_WORDS; i++) begin
      fetch_word(addr_of(i));
    end
    for (i = 0; i < N_WORDS; i++) begin
      data_access(1'b0, addr_of(i), '0, 4'hF);
    end

    // same-cycle requests, data must win
    fork
      data_access(1'b0, addr_of(3), '0, 4'hF);
      fetch_word(addr_of(5));
    join
    assert (d_done_cyc < i_done_cyc) else begin
      n_order++;
      $display("fetch completed before a data read raised in the same cycle");
    end

    // fetch raised while data is under way
    fork
      data_access(1'b0, addr_of(7), '0, 4'hF);
      begin
        @(posedge CLK);
        fetch_word(addr_of(8));
      end
    join
    assert (d_done_cyc < i_done_cyc) else begin
      n_order++;
      $display("fetch completed before the data transfer it arrived behind");
    end

    // both ports busy at once
    fork
      random_data_traffic(100);
      random_fetch_traffic(100);
    join

    // idle tail, no stray completions
    repeat (10) @(posedge CLK);

    $display("%0d reads, %0d mismatches, %0d order errors, %0d busy errors, %0d timeouts",
             n_reads, n_mismatch, n_order, n_busy, n_timeout);
    if (n_mismatch == 0 && n_order == 0 && n_busy == 0 && n_timeout == 0 && n_reads > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+src
src/mem_pkg.sv
src/memory_controller.sv
src/ram_model.sv
src/mem_subsystem_top.sv
dv/tb_mem_subsystem.sv

//--- Makefile
# Verilator flow for the memory front end

VERILATOR  ?= verilator
TOP        := tb_mem_subsystem
FLIST      := flist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := all tests passed
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail, not the exit code of the binary
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "no pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
